// File: verilog/lsu_pkg.sv
package lsu_pkg;

    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int MEM_TYPE_W = 3;

    // access type, low two bits give the size
    localparam logic [MEM_TYPE_W-1:0] MT_W  = 3'b000;
    localparam logic [MEM_TYPE_W-1:0] MT_H  = 3'b001;
    localparam logic [MEM_TYPE_W-1:0] MT_B  = 3'b010;
    localparam logic [MEM_TYPE_W-1:0] MT_HU = 3'b101;  // bit 2 set means zero extend
    localparam logic [MEM_TYPE_W-1:0] MT_BU = 3'b110;

    // one data word seen as word, halfword lanes or byte lanes
    typedef union packed {
        logic [DATA_W-1:0] w;
        logic [1:0][15:0]  h;  // h[0] is the low half
        logic [3:0][7:0]   b;  // b[0] is the low byte
    } mem_word_u;

endpackage

// File: verilog/exe_stage.sv
`timescale 1ns/1ps

module exe_stage
    import lsu_pkg::*;
(
    input  logic                  clk,
    input  logic                  resetn,

    input  logic                  in_valid,
    output logic                  in_allowin,
    input  logic                  in_mem_we,
    input  logic                  in_res_from_mem,
    input  logic                  in_gr_we,
    input  logic [MEM_TYPE_W-1:0] in_mem_type,
    input  logic [DATA_W-1:0]     in_addr,
    input  logic [DATA_W-1:0]     in_store_data,
    input  logic [DATA_W-1:0]     in_alu_result,
    input  logic [REG_ADDR_W-1:0] in_dest,
    input  logic [DATA_W-1:0]     in_pc,

    output logic                  ex_mem_valid,
    input  logic                  mem_allowin,

    output logic                  sram_en,
    output logic [3:0]            sram_wstrb,
    output logic [DATA_W-1:0]     sram_addr,
    output logic [DATA_W-1:0]     sram_wdata,

    output logic                  ex_res_from_mem,
    output logic                  ex_gr_we,
    output logic [MEM_TYPE_W-1:0] ex_mem_type,
    output logic [1:0]            ex_addr_low2,
    output logic [DATA_W-1:0]     ex_alu_result,
    output logic [REG_ADDR_W-1:0] ex_dest,
    output logic [DATA_W-1:0]     ex_pc
);

    logic              ex_valid;
    logic              ex_mem_we;
    logic [DATA_W-1:0] ex_addr;
    logic [DATA_W-1:0] ex_store_data;
    logic [3:0]        lane_mask;
    mem_word_u         st_word;

    assign ex_mem_valid = ex_valid;
    assign in_allowin   = ~ex_valid | (ex_mem_valid & mem_allowin);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ex_valid <= 1'b0;
        end else if (in_allowin) begin
            ex_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_allowin) begin
            ex_mem_we       <= in_mem_we;
            ex_res_from_mem <= in_res_from_mem;
            ex_gr_we        <= in_gr_we;
            ex_mem_type     <= in_mem_type;
            ex_addr         <= in_addr;
            ex_store_data   <= in_store_data;
            ex_alu_result   <= in_alu_result;
            ex_dest         <= in_dest;
            ex_pc           <= in_pc;
        end
    end

    assign ex_addr_low2 = ex_addr[1:0];

    always_comb begin
        case (ex_mem_type[1:0])
            MT_W[1:0]: lane_mask = 4'b1111;
            MT_H[1:0]: lane_mask = ex_addr[1] ? 4'b1100 : 4'b0011;
            default:   lane_mask = 4'b0001 << ex_addr[1:0];  // single byte lane
        endcase
    end

    // copy narrow store data into every lane, the strobe picks the live one
    always_comb begin
        case (ex_mem_type[1:0])
            MT_H[1:0]: begin
                st_word.h[1] = ex_store_data[15:0];
                st_word.h[0] = ex_store_data[15:0];
            end
            MT_B[1:0]: begin
                for (int i = 0; i < 4; i++) begin
                    st_word.b[i] = ex_store_data[7:0];
                end
            end
            default: st_word.w = ex_store_data;
        endcase
    end

    assign sram_en    = ex_mem_valid & mem_allowin;  // one access per handoff
    assign sram_wstrb = (ex_valid & ex_mem_we) ? lane_mask : 4'b0000;
    assign sram_addr  = ex_addr;
    assign sram_wdata = st_word.w;

endmodule

// File: verilog/data_sram.sv
`timescale 1ns/1ps

module data_sram
    import lsu_pkg::*;
#(
    parameter int ADDR_DEPTH_LOG2 = 10
) (
    input  logic              clk,
    input  logic              en,
    input  logic [3:0]        wstrb,
    input  logic [DATA_W-1:0] addr,
    input  logic [DATA_W-1:0] wdata,
    output logic [DATA_W-1:0] rdata
);

    localparam int DEPTH = 1 << ADDR_DEPTH_LOG2;

    logic [DATA_W-1:0]          mem [0:DEPTH-1];
    logic [ADDR_DEPTH_LOG2-1:0] word_idx;

    assign word_idx = addr[ADDR_DEPTH_LOG2+1:2];  // wraps at the depth

    always_ff @(posedge clk) begin
        if (en) begin
            for (int i = 0; i < 4; i++) begin
                if (wstrb[i]) begin
                    mem[word_idx][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
            rdata <= mem[word_idx];  // read before write
        end
    end

endmodule

// File: verilog/mem_stage.sv
`timescale 1ns/1ps

module mem_stage
    import lsu_pkg::*;
(
    input  logic                  clk,
    input  logic                  resetn,

    input  logic                  ex_mem_valid,
    output logic                  mem_allowin,
    input  logic                  ex_res_from_mem,
    input  logic                  ex_gr_we,
    input  logic [MEM_TYPE_W-1:0] ex_mem_type,
    input  logic [1:0]            ex_addr_low2,
    input  logic [DATA_W-1:0]     ex_alu_result,
    input  logic [REG_ADDR_W-1:0] ex_dest,
    input  logic [DATA_W-1:0]     ex_pc,

    input  logic [DATA_W-1:0]     sram_rdata,

    output logic                  mem_wb_valid,
    input  logic                  wb_allowin,
    output logic                  mem_gr_we,
    output logic [REG_ADDR_W-1:0] mem_dest,
    output logic [DATA_W-1:0]     mem_pc,
    output logic [DATA_W-1:0]     mem_final_result,

    output logic                  mem_fwd_valid
);

    logic                  mem_valid;
    logic                  mem_res_from_mem;
    logic [MEM_TYPE_W-1:0] mem_type;
    logic [1:0]            mem_addr_low2;
    logic [DATA_W-1:0]     mem_alu_result;
    mem_word_u             ld_word;
    logic [15:0]           ld_half;
    logic [7:0]            ld_byte;
    logic [DATA_W-1:0]     load_data;

    assign mem_wb_valid = mem_valid;  // sram data is already back
    assign mem_allowin  = ~mem_valid | (mem_wb_valid & wb_allowin);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            mem_valid <= 1'b0;
        end else if (mem_allowin) begin
            mem_valid <= ex_mem_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_mem_valid && mem_allowin) begin
            mem_res_from_mem <= ex_res_from_mem;
            mem_gr_we        <= ex_gr_we;
            mem_type         <= ex_mem_type;
            mem_addr_low2    <= ex_addr_low2;
            mem_alu_result   <= ex_alu_result;
            mem_dest         <= ex_dest;
            mem_pc           <= ex_pc;
        end
    end

    assign ld_word.w = sram_rdata;
    assign ld_half   = ld_word.h[mem_addr_low2[1]];
    assign ld_byte   = ld_word.b[mem_addr_low2];

    always_comb begin
        case (mem_type)
            MT_H:    load_data = {{16{ld_half[15]}}, ld_half};
            MT_B:    load_data = {{24{ld_byte[7]}}, ld_byte};
            MT_HU:   load_data = {16'b0, ld_half};
            MT_BU:   load_data = {24'b0, ld_byte};
            default: load_data = ld_word.w;  // ld.w
        endcase
    end

    assign mem_final_result = mem_res_from_mem ? load_data : mem_alu_result;

    // bypass toward decode
    assign mem_fwd_valid = mem_valid & mem_gr_we;

endmodule

// File: verilog/wb_stage.sv
`timescale 1ns/1ps

module wb_stage
    import lsu_pkg::*;
(
    input  logic                  clk,
    input  logic                  resetn,

    input  logic                  mem_wb_valid,
    output logic                  wb_allowin,
    input  logic                  mem_gr_we,
    input  logic [REG_ADDR_W-1:0] mem_dest,
    input  logic [DATA_W-1:0]     mem_pc,
    input  logic [DATA_W-1:0]     mem_final_result,
    input  logic                  commit_hold,

    output logic                  rf_we,
    output logic [REG_ADDR_W-1:0] rf_waddr,
    output logic [DATA_W-1:0]     rf_wdata,

    output logic                  debug_wb_valid,
    output logic [DATA_W-1:0]     debug_wb_pc,
    output logic                  debug_wb_rf_we,
    output logic [REG_ADDR_W-1:0] debug_wb_rf_wnum,
    output logic [DATA_W-1:0]     debug_wb_rf_wdata
);

    logic                  wb_valid;
    logic                  wb_gr_we;
    logic [REG_ADDR_W-1:0] wb_dest;
    logic [DATA_W-1:0]     wb_pc;
    logic [DATA_W-1:0]     wb_result;

    assign wb_allowin = ~commit_hold;  // hold freezes the stage even when empty

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wb_valid <= 1'b0;
        end else if (wb_allowin) begin
            wb_valid <= mem_wb_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_wb_valid && wb_allowin) begin
            wb_gr_we  <= mem_gr_we;
            wb_dest   <= mem_dest;
            wb_pc     <= mem_pc;
            wb_result <= mem_final_result;
        end
    end

    assign debug_wb_valid    = wb_valid & ~commit_hold;  // retire strobe
    assign rf_we             = debug_wb_valid & wb_gr_we;
    assign rf_waddr          = wb_dest;
    assign rf_wdata          = wb_result;

    assign debug_wb_pc       = wb_pc;
    assign debug_wb_rf_we    = rf_we;
    assign debug_wb_rf_wnum  = wb_dest;
    assign debug_wb_rf_wdata = wb_result;

endmodule

// File: verilog/reg_file.sv
`timescale 1ns/1ps

module reg_file
    import lsu_pkg::*;
(
    input  logic                  clk,
    input  logic                  we,
    input  logic [REG_ADDR_W-1:0] waddr,
    input  logic [DATA_W-1:0]     wdata,
    input  logic [REG_ADDR_W-1:0] raddr1,
    input  logic [REG_ADDR_W-1:0] raddr2,
    output logic [DATA_W-1:0]     rdata1,
    output logic [DATA_W-1:0]     rdata2
);

    // r0 has no storage
    logic [DATA_W-1:0] regs [1:(1<<REG_ADDR_W)-1];

    always_ff @(posedge clk) begin
        if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    // combinational reads, no write bypass
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// File: verilog/lsu_pipe_top.sv
`timescale 1ns/1ps

module lsu_pipe_top
    import lsu_pkg::*;
#(
    parameter int ADDR_DEPTH_LOG2 = 10
) (
    input  logic                  clk,
    input  logic                  resetn,

    input  logic                  in_valid,
    output logic                  in_allowin,
    input  logic                  in_mem_we,
    input  logic                  in_res_from_mem,
    input  logic                  in_gr_we,
    input  logic [MEM_TYPE_W-1:0] in_mem_type,
    input  logic [DATA_W-1:0]     in_addr,
    input  logic [DATA_W-1:0]     in_store_data,
    input  logic [DATA_W-1:0]     in_alu_result,
    input  logic [REG_ADDR_W-1:0] in_dest,
    input  logic [DATA_W-1:0]     in_pc,

    input  logic                  commit_hold,

    output logic                  mem_fwd_valid,
    output logic [REG_ADDR_W-1:0] mem_fwd_dest,
    output logic [DATA_W-1:0]     mem_fwd_data,

    output logic                  debug_wb_valid,
    output logic [DATA_W-1:0]     debug_wb_pc,
    output logic                  debug_wb_rf_we,
    output logic [REG_ADDR_W-1:0] debug_wb_rf_wnum,
    output logic [DATA_W-1:0]     debug_wb_rf_wdata,

    input  logic [REG_ADDR_W-1:0] rf_raddr1,
    output logic [DATA_W-1:0]     rf_rdata1,
    input  logic [REG_ADDR_W-1:0] rf_raddr2,
    output logic [DATA_W-1:0]     rf_rdata2
);

    logic                  ex_mem_valid;
    logic                  mem_allowin;
    logic                  sram_en;
    logic [3:0]            sram_wstrb;
    logic [DATA_W-1:0]     sram_addr;
    logic [DATA_W-1:0]     sram_wdata;
    logic [DATA_W-1:0]     sram_rdata;
    logic                  ex_res_from_mem;
    logic                  ex_gr_we;
    logic [MEM_TYPE_W-1:0] ex_mem_type;
    logic [1:0]            ex_addr_low2;
    logic [DATA_W-1:0]     ex_alu_result;
    logic [REG_ADDR_W-1:0] ex_dest;
    logic [DATA_W-1:0]     ex_pc;
    logic                  mem_wb_valid;
    logic                  wb_allowin;
    logic                  mem_gr_we;
    logic [DATA_W-1:0]     mem_pc;
    logic                  rf_we;
    logic [REG_ADDR_W-1:0] rf_waddr;
    logic [DATA_W-1:0]     rf_wdata;

    exe_stage i_exe_stage (
        .clk, .resetn,
        .in_valid, .in_allowin, .in_mem_we, .in_res_from_mem, .in_gr_we,
        .in_mem_type, .in_addr, .in_store_data, .in_alu_result, .in_dest, .in_pc,
        .ex_mem_valid, .mem_allowin,
        .sram_en, .sram_wstrb, .sram_addr, .sram_wdata,
        .ex_res_from_mem, .ex_gr_we, .ex_mem_type, .ex_addr_low2,
        .ex_alu_result, .ex_dest, .ex_pc
    );

    data_sram #(
        .ADDR_DEPTH_LOG2(ADDR_DEPTH_LOG2)
    ) i_data_sram (
        .clk   (clk),
        .en    (sram_en),
        .wstrb (sram_wstrb),
        .addr  (sram_addr),
        .wdata (sram_wdata),
        .rdata (sram_rdata)
    );

    // forwarding bus is the memory stage's dest and result
    mem_stage i_mem_stage (
        .clk, .resetn,
        .ex_mem_valid, .mem_allowin,
        .ex_res_from_mem, .ex_gr_we, .ex_mem_type, .ex_addr_low2,
        .ex_alu_result, .ex_dest, .ex_pc,
        .sram_rdata,
        .mem_wb_valid, .wb_allowin, .mem_gr_we,
        .mem_dest         (mem_fwd_dest),
        .mem_pc,
        .mem_final_result (mem_fwd_data),
        .mem_fwd_valid
    );

    wb_stage i_wb_stage (
        .clk, .resetn,
        .mem_wb_valid, .wb_allowin, .mem_gr_we,
        .mem_dest         (mem_fwd_dest),
        .mem_pc,
        .mem_final_result (mem_fwd_data),
        .commit_hold,
        .rf_we, .rf_waddr, .rf_wdata,
        .debug_wb_valid, .debug_wb_pc, .debug_wb_rf_we,
        .debug_wb_rf_wnum, .debug_wb_rf_wdata
    );

    reg_file i_reg_file (
        .clk    (clk),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata),
        .raddr1 (rf_raddr1),
        .raddr2 (rf_raddr2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2)
    );

endmodule

// File: dv/lsu_pipe_chk.sv
`timescale 1ns/1ps

module lsu_pipe_chk (
    input logic clk,
    input logic resetn,
    input logic sram_en,
    input logic mem_allowin,
    input logic commit_hold,
    input logic debug_wb_valid,
    input logic mem_fwd_valid,
    input logic mem_wb_valid
);

    int fail_count = 0;

    // no access into a blocked memory stage
    sram_en_needs_allowin: assert property (@(posedge clk) disable iff (!resetn)
        sram_en |-> mem_allowin)
        else begin
            $error("sram_en high while mem_allowin is low");
            fail_count++;
        end

    hold_blocks_retire: assert property (@(posedge clk) disable iff (!resetn)
        commit_hold |-> !debug_wb_valid)
        else begin
            $error("debug_wb_valid high during commit_hold");
            fail_count++;
        end

    fwd_needs_mem_valid: assert property (@(posedge clk) disable iff (!resetn)
        mem_fwd_valid |-> mem_wb_valid)
        else begin
            $error("mem_fwd_valid high with an empty memory stage");
            fail_count++;
        end

endmodule

bind lsu_pipe_top lsu_pipe_chk i_chk (.*);

// File: dv/lsu_pipe_tb.sv
`timescale 1ns/1ps

module lsu_pipe_tb
    import lsu_pkg::*;
();

    localparam logic [3:0] OP_SW  = {1'b1, MT_W};
    localparam logic [3:0] OP_SH  = {1'b1, MT_H};
    localparam logic [3:0] OP_SB  = {1'b1, MT_B};
    localparam logic [3:0] OP_LW  = {1'b0, MT_W};
    localparam logic [3:0] OP_LH  = {1'b0, MT_H};
    localparam logic [3:0] OP_LB  = {1'b0, MT_B};
    localparam logic [3:0] OP_LHU = {1'b0, MT_HU};
    localparam logic [3:0] OP_LBU = {1'b0, MT_BU};

    typedef struct packed {
        logic [3:0]  op;  // store flag above the access type
        logic [31:0] addr;
        logic [31:0] data;
        logic [4:0]  dest;
        logic [31:0] pc;
    } entry_t;

    typedef struct packed {
        logic [31:0] pc;
        logic        we;
        logic [4:0]  dest;
        logic [31:0] data;
        logic [31:0] cyc;
        logic        timed;  // accepted with hold disabled
    } retire_t;

    logic                  clk;
    logic                  resetn;
    logic                  in_valid;
    logic                  in_allowin;
    logic                  in_mem_we;
    logic                  in_res_from_mem;
    logic                  in_gr_we;
    logic [MEM_TYPE_W-1:0] in_mem_type;
    logic [DATA_W-1:0]     in_addr;
    logic [DATA_W-1:0]     in_store_data;
    logic [DATA_W-1:0]     in_alu_result;
    logic [REG_ADDR_W-1:0] in_dest;
    logic [DATA_W-1:0]     in_pc;
    logic                  commit_hold;
    logic                  mem_fwd_valid;
    logic [REG_ADDR_W-1:0] mem_fwd_dest;
    logic [DATA_W-1:0]     mem_fwd_data;
    logic                  debug_wb_valid;
    logic [DATA_W-1:0]     debug_wb_pc;
    logic                  debug_wb_rf_we;
    logic [REG_ADDR_W-1:0] debug_wb_rf_wnum;
    logic [DATA_W-1:0]     debug_wb_rf_wdata;
    logic [REG_ADDR_W-1:0] rf_raddr1;
    logic [DATA_W-1:0]     rf_rdata1;
    logic [REG_ADDR_W-1:0] rf_raddr2;
    logic [DATA_W-1:0]     rf_rdata2;

    entry_t      stim_q[$];
    retire_t     retire_q[$];
    logic [7:0]  ref_mem [0:4095];
    logic [31:0] model_rf [0:31];
    logic        ex_v;
    logic        mem_v;
    logic        wb_v;
    logic        hold_en;
    logic        table_ready;
    int          seed = 93;
    int          cyc;
    int          retired;
    int          value_errs;
    int          other_errs;

    lsu_pipe_top #(.ADDR_DEPTH_LOG2(10)) i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic expect_eq(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error @%0t: %s = %h, expected %h", $time, name, got, exp);
            value_errs++;
        end
    endtask

    task automatic add_entry(input logic [3:0] op, input logic [31:0] addr,
                             input logic [31:0] data, input logic [4:0] dest);
        stim_q.push_back({op, addr, data, dest, 32'h1c00_0000 + 4 * stim_q.size()});
    endtask

    task automatic build_table();
        add_entry(OP_SW, 32'h100, 32'h80ff_7f01, 5'd0);
        add_entry(OP_LW, 32'h100, 32'h0, 5'd1);
        for (int i = 0; i < 4; i++) begin
            add_entry(OP_LB, 32'h100 + i, 32'h0, 5'd2 + i);
            add_entry(OP_LBU, 32'h100 + i, 32'h0, 5'd6 + i);
        end
        for (int i = 0; i < 2; i++) begin
            add_entry(OP_LH, 32'h100 + 2 * i, 32'h0, 5'd10 + i);
            add_entry(OP_LHU, 32'h100 + 2 * i, 32'h0, 5'd12 + i);
        end
        // narrow stores over known words
        add_entry(OP_SW, 32'h104, 32'h1122_3344, 5'd0);
        add_entry(OP_SB, 32'h105, 32'h5555_55aa, 5'd0);
        add_entry(OP_SH, 32'h106, 32'hcafe_beef, 5'd0);
        add_entry(OP_LW, 32'h104, 32'h0, 5'd14);
        add_entry(OP_SW, 32'h108, 32'hdead_beef, 5'd3);
        add_entry(OP_SB, 32'h10b, 32'h0000_009c, 5'd0);
        add_entry(OP_SB, 32'h10a, 32'h0000_0071, 5'd0);
        add_entry(OP_SH, 32'h108, 32'h7777_1234, 5'd0);
        add_entry(OP_LW, 32'h108, 32'h0, 5'd15);
        add_entry(OP_LW, 32'h100, 32'h0, 5'd0);  // r0 must stay zero
        add_entry(OP_LB, 32'h103, 32'h0, 5'd0);
        add_entry(OP_LW, 32'h104, 32'h0, 5'd16);
        add_entry(OP_LHU, 32'h10a, 32'h0, 5'd16);  // same dest back to back
    endtask

    task automatic write_model(input logic [2:0] mt, input logic [31:0] addr,
                               input logic [31:0] data);
        logic [11:0] a;
        a = addr[11:0];
        case (mt[1:0])
            2'b00: begin
                for (int i = 0; i < 4; i++) begin
                    ref_mem[{a[11:2], 2'b00} + i] = data[8*i +: 8];
                end
            end
            2'b01: begin
                ref_mem[{a[11:1], 1'b0}] = data[7:0];
                ref_mem[{a[11:1], 1'b1}] = data[15:8];
            end
            default: ref_mem[a] = data[7:0];
        endcase
    endtask

    function automatic logic [31:0] load_value(input logic [2:0] mt, input logic [31:0] addr);
        logic [11:0] a;
        logic [15:0] half;
        logic [7:0]  byte_v;
        a = addr[11:0];
        half = {ref_mem[{a[11:1], 1'b1}], ref_mem[{a[11:1], 1'b0}]};
        byte_v = ref_mem[a];
        case (mt)
            MT_H:    return {{16{half[15]}}, half};
            MT_HU:   return {16'h0, half};
            MT_B:    return {{24{byte_v[7]}}, byte_v};
            MT_BU:   return {24'h0, byte_v};
            default: return {ref_mem[{a[11:2], 2'd3}], ref_mem[{a[11:2], 2'd2}],
                             ref_mem[{a[11:2], 2'd1}], ref_mem[{a[11:2], 2'd0}]};
        endcase
    endfunction

    // runs from 2 ns after an edge to 2 ns after the accepting edge
    task automatic apply_entry(input entry_t e, input int pass);
        logic took;
        in_valid        = 1'b1;
        in_mem_we       = e.op[3];
        in_res_from_mem = !e.op[3];
        in_gr_we        = !e.op[3];
        in_mem_type     = e.op[2:0];
        in_addr         = e.addr;
        in_store_data   = e.data;
        in_alu_result   = e.addr;
        in_dest         = e.dest;
        in_pc           = e.pc + pass * 32'h400;
        do begin
            @(negedge clk);
            took = in_allowin;
            @(posedge clk);
            #2;
        end while (!took);
        in_valid = 1'b0;
    endtask

    initial begin
        logic hold_now;
        forever begin
            @(posedge clk);
            hold_now = hold_en;
            #2 commit_hold = hold_now ? (($random(seed) & 3) == 0) : 1'b0;
        end
    end

    // cycle model of stage occupancy from the valid/allowin rules
    initial begin
        retire_t     r;
        logic        wb_allow;
        logic        mem_allow;
        logic        ex_allow;
        logic        pend_we;
        logic [4:0]  pend_dest;
        logic [31:0] pend_data;
        wait (resetn === 1'b1);
        forever begin
            @(negedge clk);
            wb_allow  = !commit_hold;
            mem_allow = !mem_v || wb_allow;
            ex_allow  = !ex_v || mem_allow;
            expect_eq("in_allowin", in_allowin, ex_allow);
            expect_eq("debug_wb_valid", debug_wb_valid, wb_v && wb_allow);
            expect_eq("mem_fwd_valid", mem_fwd_valid, mem_v ? retire_q[wb_v].we : 1'b0);
            if (mem_v && retire_q[wb_v].we) begin
                expect_eq("mem_fwd_dest", mem_fwd_dest, retire_q[wb_v].dest);
                expect_eq("mem_fwd_data", mem_fwd_data, retire_q[wb_v].data);
            end
            pend_we = 1'b0;
            if (wb_v && wb_allow) begin
                r = retire_q.pop_front();
                expect_eq("debug_wb_pc", debug_wb_pc, r.pc);
                expect_eq("debug_wb_rf_we", debug_wb_rf_we, r.we);
                expect_eq("debug_wb_rf_wnum", debug_wb_rf_wnum, r.dest);
                if (r.we) begin
                    expect_eq("debug_wb_rf_wdata", debug_wb_rf_wdata, r.data);
                end
                if (r.timed && cyc != r.cyc + 3) begin
                    $display("pc %h retired %0d cycles after acceptance instead of 3",
                             r.pc, cyc - r.cyc);
                    other_errs++;
                end
                pend_we   = r.we;
                pend_dest = r.dest;
                pend_data = r.data;
                retired++;
            end
            expect_eq("rf_rdata1", rf_rdata1, model_rf[rf_raddr1]);
            expect_eq("rf_rdata2", rf_rdata2, model_rf[rf_raddr2]);
            if (in_valid && ex_allow) begin
                r.pc    = in_pc;
                r.we    = in_gr_we;
                r.dest  = in_dest;
                r.cyc   = cyc;
                r.timed = !hold_en;
                if (in_mem_we) begin
                    write_model(in_mem_type, in_addr, in_store_data);
                    r.data = in_alu_result;
                end else begin
                    r.data = load_value(in_mem_type, in_addr);
                end
                retire_q.push_back(r);
            end
            if (wb_allow) wb_v = mem_v;
            if (mem_allow) mem_v = ex_v;
            if (ex_allow) ex_v = in_valid;
            @(posedge clk);
            cyc++;
            if (pend_we && pend_dest != 5'd0) model_rf[pend_dest] = pend_data;
            #2;
            if (pend_we) begin
                rf_raddr2 = rf_raddr1;  // previous write target
                rf_raddr1 = pend_dest;  // look at the freshly written reg
            end
        end
    end

    initial begin
        wait (table_ready === 1'b1);
        repeat (2 * stim_q.size() * 20) @(posedge clk);
        $display("timeout, %0d instructions never retired", retire_q.size());
        $display("Test failed");
        $finish;
    end

    initial begin
        resetn          = 1'b0;
        in_valid        = 1'b0;
        in_mem_we       = 1'b0;
        in_res_from_mem = 1'b0;
        in_gr_we        = 1'b0;
        in_mem_type     = '0;
        in_addr         = '0;
        in_store_data   = '0;
        in_alu_result   = '0;
        in_dest         = '0;
        in_pc           = '0;
        commit_hold     = 1'b0;
        rf_raddr1       = '0;
        rf_raddr2       = '0;
        hold_en         = 1'b0;
        ex_v            = 1'b0;
        mem_v           = 1'b0;
        wb_v            = 1'b0;
        model_rf[0]     = 32'h0;
        build_table();
        table_ready = 1'b1;
        repeat (4) @(posedge clk);
        #2 resetn = 1'b1;
        // second pass adds random hold
        for (int pass = 0; pass < 2; pass++) begin
            hold_en = (pass == 1);
            foreach (stim_q[i]) begin
                apply_entry(stim_q[i], pass);
            end
            @(posedge clk);
            while (retire_q.size() != 0) @(posedge clk);
            #2;
        end
        @(posedge clk);
        hold_en = 1'b0;
        if (retired != 2 * stim_q.size()) begin
            $display("retired %0d instructions, %0d were issued", retired, 2 * stim_q.size());
            other_errs++;
        end
        other_errs += i_dut.i_chk.fail_count;
        $display("summary: %0d value errors, %0d other errors, %0d retired",
                 value_errs, other_errs, retired);
        if (value_errs == 0 && other_errs == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: flist.f
verilog/lsu_pkg.sv
verilog/exe_stage.sv
verilog/data_sram.sv
verilog/mem_stage.sv
verilog/wb_stage.sv
verilog/reg_file.sv
verilog/lsu_pipe_top.sv
dv/lsu_pipe_chk.sv
dv/lsu_pipe_tb.sv

// File: Bender.yml
package:
  name: lsu_pipe

sources:
  - verilog/lsu_pkg.sv
  - verilog/exe_stage.sv
  - verilog/data_sram.sv
  - verilog/mem_stage.sv
  - verilog/wb_stage.sv
  - verilog/reg_file.sv
  - verilog/lsu_pipe_top.sv
  - target: test
    files:
      - dv/lsu_pipe_chk.sv
      - dv/lsu_pipe_tb.sv
